// File: src/gat_pkg.sv
package gat_pkg;

  // Sizes for the scaled-down layer
  localparam int DATA_W       = 8;
  localparam int NUM_FEAT_IN  = 16;
  localparam int NUM_FEAT_OUT = 4;
  localparam int COL_W        = $clog2(NUM_FEAT_IN);
  localparam int ROW_LEN_W    = $clog2(NUM_FEAT_IN + 1);
  localparam int H_ADDR_W     = 6;
  localparam int NODE_ADDR_W  = 4;
  localparam int NODE_CNT_W   = NODE_ADDR_W + 1;
  localparam int WH_DATA_W    = 20;
  localparam int COEF_W       = 32;
  localparam int LEAKY_SHIFT  = 3;

  localparam int FIFO_DEPTH   = 8;
  localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W   = $clog2(FIFO_DEPTH + 1);

  typedef logic signed [DATA_W-1:0]    data_t;
  typedef logic [COL_W-1:0]            col_idx_t;
  typedef logic [ROW_LEN_W-1:0]        row_len_t;
  typedef logic [H_ADDR_W-1:0]         h_addr_t;
  typedef logic [NODE_ADDR_W-1:0]      node_addr_t;
  typedef logic [NODE_CNT_W-1:0]       node_cnt_t;
  typedef logic signed [WH_DATA_W-1:0] wh_data_t;
  typedef logic signed [COEF_W-1:0]    coef_t;
  typedef logic [FIFO_AW-1:0]          fifo_ptr_t;
  typedef logic [FIFO_CNT_W-1:0]       fifo_cnt_t;

  // One nonzero element of a compressed feature row
  typedef struct packed {
    data_t    value;
    col_idx_t col;
  } h_entry_t;

  // is_target marks the first node of a subgraph
  typedef struct packed {
    row_len_t row_len;
    logic     is_target;
  } node_info_t;

  typedef struct packed {
    data_t [NUM_FEAT_OUT-1:0] w;
  } wgt_row_t;

  // Self half pairs with the target, neighbour half with the node itself
  typedef struct packed {
    data_t [NUM_FEAT_OUT-1:0] self_half;
    data_t [NUM_FEAT_OUT-1:0] nbr_half;
  } attn_vec_t;

  typedef struct packed {
    wh_data_t [NUM_FEAT_OUT-1:0] feat;
    logic                        is_target;
  } wh_t;

endpackage

// File: src/sparse_feature_mult.sv
module sparse_feature_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  gat_pkg::node_cnt_t  node_cnt_i,
  output gat_pkg::node_addr_t node_addr_o,
  input  gat_pkg::node_info_t node_info_i,
  output gat_pkg::h_addr_t    h_addr_o,
  input  gat_pkg::h_entry_t   h_entry_i,
  output gat_pkg::col_idx_t   w_addr_o,
  input  gat_pkg::wgt_row_t   w_row_i,
  output gat_pkg::wh_t        wh_o,
  output logic                wh_valid_o,
  input  logic                wh_ready_i,
  output logic                last_o,
  input  logic                run_done_i,
  output logic                ready_o
);

  typedef enum logic [2:0] {
    IDLE,
    NODE_FETCH,
    ROW_READ,
    ROW_DRAIN,
    EMIT,
    WAIT_DONE
  } state_e;

  state_e                                        state;
  gat_pkg::node_cnt_t                            node_cnt_q;
  gat_pkg::node_cnt_t                            node_idx;
  gat_pkg::h_addr_t                              h_ptr;
  gat_pkg::row_len_t                             rem;
  logic                                          tgt_q;
  logic                                          rd_v1;
  logic                                          rd_v2;
  logic                                          last_node;
  gat_pkg::data_t                                val_q;
  gat_pkg::wh_data_t [gat_pkg::NUM_FEAT_OUT-1:0] acc;
  logic signed [2*gat_pkg::DATA_W-1:0]           prod [gat_pkg::NUM_FEAT_OUT];

  // node_idx runs one ahead so the next node-info word is ready in NODE_FETCH
  assign node_addr_o = node_idx[gat_pkg::NODE_ADDR_W-1:0];
  assign h_addr_o    = h_ptr;
  // Weight row follows the column of the entry just returned
  assign w_addr_o    = h_entry_i.col;
  assign last_node   = (node_idx == node_cnt_q);
  assign ready_o     = (state == IDLE);
  assign wh_valid_o  = (state == EMIT);
  assign last_o      = wh_valid_o && last_node;
  assign wh_o        = '{feat: acc, is_target: tgt_q};

  always_comb begin
    for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
      prod[j] = $signed(val_q) * $signed(w_row_i.w[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      node_cnt_q <= '0;
      node_idx   <= '0;
      h_ptr      <= '0;
      rem        <= '0;
      rd_v1      <= 1'b0;
      rd_v2      <= 1'b0;
    end else begin
      rd_v1 <= (state == ROW_READ);
      rd_v2 <= rd_v1;
      case (state)
        IDLE: begin
          if (start_i) begin
            node_cnt_q <= node_cnt_i;
            state      <= NODE_FETCH;
          end
        end
        NODE_FETCH: begin
          // Only reached with last_node set when the count is zero
          if (last_node) begin
            state <= IDLE;
          end else begin
            rem      <= node_info_i.row_len;
            node_idx <= node_idx + 1'b1;
            if (node_info_i.row_len == '0) begin
              state <= ROW_DRAIN;
            end else begin
              state <= ROW_READ;
            end
          end
        end
        ROW_READ: begin
          h_ptr <= h_ptr + 1'b1;
          rem   <= rem - 1'b1;
          if (rem == gat_pkg::row_len_t'(1)) begin
            state <= ROW_DRAIN;
          end
        end
        ROW_DRAIN: begin
          // Last product lands in acc on this edge
          if (!rd_v1) begin
            state <= EMIT;
          end
        end
        EMIT: begin
          if (wh_ready_i) begin
            if (last_node) begin
              state <= WAIT_DONE;
            end else begin
              state <= NODE_FETCH;
            end
          end
        end
        WAIT_DONE: begin
          if (run_done_i) begin
            node_idx <= '0;
            h_ptr    <= '0;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_v1) begin
      val_q <= h_entry_i.value;
    end
    if (state == NODE_FETCH) begin
      tgt_q <= node_info_i.is_target;
      acc   <= '0;
    end else if (rd_v2) begin
      for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
        acc[j] <= acc[j] + prod[j];
      end
    end
  end

endmodule

// File: src/attention_coef.sv
module attention_coef (
  input  logic               clk,
  input  logic               rst_n,
  input  gat_pkg::attn_vec_t attn_i,
  input  gat_pkg::wh_t       wh_i,
  input  logic               wh_valid_i,
  output logic               wh_ready_o,
  input  logic               last_i,
  output gat_pkg::coef_t     coef_o,
  output logic               push_o,
  input  logic               full_i,
  output logic               run_done_o
);

  gat_pkg::coef_t self_dot;
  gat_pkg::coef_t nbr_dot;
  gat_pkg::coef_t tgt_dot;
  gat_pkg::coef_t s1_self;
  gat_pkg::coef_t s1_nbr;
  gat_pkg::coef_t sum;
  gat_pkg::coef_t leaky;
  gat_pkg::coef_t s2_coef;
  logic           s1_v;
  logic           s1_last;
  logic           s2_v;
  logic           s2_last;
  logic           stall;
  logic           take;

  always_comb begin
    self_dot = '0;
    nbr_dot  = '0;
    for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
      self_dot = self_dot + $signed(attn_i.self_half[j]) * $signed(wh_i.feat[j]);
      nbr_dot  = nbr_dot + $signed(attn_i.nbr_half[j]) * $signed(wh_i.feat[j]);
    end
  end

  // Both stages hold while the output stage cannot push
  assign stall      = s2_v && full_i;
  assign wh_ready_o = !stall;
  assign take       = wh_valid_i && wh_ready_o;

  assign sum   = s1_self + s1_nbr;
  assign leaky = (sum < 0) ? (sum >>> gat_pkg::LEAKY_SHIFT) : sum;

  assign coef_o     = s2_coef;
  assign push_o     = s2_v && !full_i;
  assign run_done_o = push_o && s2_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_v    <= 1'b0;
      s1_last <= 1'b0;
      s2_v    <= 1'b0;
      s2_last <= 1'b0;
    end else if (!stall) begin
      s1_v    <= wh_valid_i;
      s1_last <= wh_valid_i && last_i;
      s2_v    <= s1_v;
      s2_last <= s1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (take && wh_i.is_target) begin
      tgt_dot <= self_dot;
    end
    if (!stall) begin
      s1_nbr  <= nbr_dot;
      // Self term is bound per item so a new target cannot overtake stage 2
      s1_self <= wh_i.is_target ? self_dot : tgt_dot;
      s2_coef <= leaky;
    end
  end

endmodule

// File: src/coef_fifo.sv
module coef_fifo (
  input  logic           clk,
  input  logic           rst_n,
  input  gat_pkg::coef_t din_i,
  input  logic           push_i,
  output logic           full_o,
  output gat_pkg::coef_t dout_o,
  output logic           valid_o,
  input  logic           ready_i
);

  gat_pkg::coef_t     mem [gat_pkg::FIFO_DEPTH];
  gat_pkg::fifo_ptr_t wr_ptr;
  gat_pkg::fifo_ptr_t rd_ptr;
  gat_pkg::fifo_cnt_t count;
  logic               pop;

  assign valid_o = (count != '0);
  assign full_o  = (count == gat_pkg::fifo_cnt_t'(gat_pkg::FIFO_DEPTH));
  assign dout_o  = mem[rd_ptr];
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == gat_pkg::fifo_ptr_t'(gat_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == gat_pkg::fifo_ptr_t'(gat_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: src/gat_coef_top.sv
module gat_coef_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  gat_pkg::node_cnt_t  node_cnt_i,
  input  gat_pkg::attn_vec_t  attn_i,
  output gat_pkg::node_addr_t node_addr_o,
  input  gat_pkg::node_info_t node_info_i,
  output gat_pkg::h_addr_t    h_addr_o,
  input  gat_pkg::h_entry_t   h_entry_i,
  output gat_pkg::col_idx_t   w_addr_o,
  input  gat_pkg::wgt_row_t   w_row_i,
  output gat_pkg::coef_t      coef_o,
  output logic                coef_valid_o,
  input  logic                coef_ready_i,
  output logic                ready_o
);

  gat_pkg::wh_t   wh;
  logic           wh_valid;
  logic           wh_ready;
  logic           wh_last;
  gat_pkg::coef_t coef;
  logic           coef_push;
  logic           fifo_full;
  logic           run_done;

  // Idle level is held low until the last coefficient is in the FIFO
  sparse_feature_mult u_spmm (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .node_cnt_i  (node_cnt_i),
    .node_addr_o (node_addr_o),
    .node_info_i (node_info_i),
    .h_addr_o    (h_addr_o),
    .h_entry_i   (h_entry_i),
    .w_addr_o    (w_addr_o),
    .w_row_i     (w_row_i),
    .wh_o        (wh),
    .wh_valid_o  (wh_valid),
    .wh_ready_i  (wh_ready),
    .last_o      (wh_last),
    .run_done_i  (run_done),
    .ready_o     (ready_o)
  );

  attention_coef u_attn (
    .clk        (clk),
    .rst_n      (rst_n),
    .attn_i     (attn_i),
    .wh_i       (wh),
    .wh_valid_i (wh_valid),
    .wh_ready_o (wh_ready),
    .last_i     (wh_last),
    .coef_o     (coef),
    .push_o     (coef_push),
    .full_i     (fifo_full),
    .run_done_o (run_done)
  );

  coef_fifo u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .din_i   (coef),
    .push_i  (coef_push),
    .full_o  (fifo_full),
    .dout_o  (coef_o),
    .valid_o (coef_valid_o),
    .ready_i (coef_ready_i)
  );

endmodule

// File: sim/tb_clock.sv
module tb_clock (
  output logic clk_o
);

  // 10 time unit period
  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

endmodule

// File: sim/gat_coef_tb.sv
module gat_coef_tb;

  logic                clk;
  logic                rst_n;
  logic                start;
  gat_pkg::node_cnt_t  node_cnt;
  gat_pkg::attn_vec_t  attn;
  gat_pkg::node_addr_t node_addr;
  gat_pkg::h_addr_t    h_addr;
  gat_pkg::col_idx_t   w_addr;
  gat_pkg::node_info_t node_info = '0;
  gat_pkg::h_entry_t   h_entry = '0;
  gat_pkg::wgt_row_t   w_row = '0;
  gat_pkg::coef_t      coef;
  logic                coef_valid;
  logic                coef_ready;
  logic                ready;

  gat_pkg::node_info_t node_mem [16];
  gat_pkg::h_entry_t   h_mem [64];
  gat_pkg::wgt_row_t   w_mem [16];
  gat_pkg::coef_t      exp_q [$];
  gat_pkg::coef_t      got_q [$];
  logic [31:0]         rng;
  int                  errors;
  int                  timeouts;

  tb_clock u_clock (.clk_o(clk));

  gat_coef_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start),
    .node_cnt_i   (node_cnt),
    .attn_i       (attn),
    .node_addr_o  (node_addr),
    .node_info_i  (node_info),
    .h_addr_o     (h_addr),
    .h_entry_i    (h_entry),
    .w_addr_o     (w_addr),
    .w_row_i      (w_row),
    .coef_o       (coef),
    .coef_valid_o (coef_valid),
    .coef_ready_i (coef_ready),
    .ready_o      (ready)
  );

  // External memories, one cycle read latency
  always @(posedge clk) begin
    node_info <= node_mem[node_addr];
    h_entry   <= h_mem[h_addr];
    w_row     <= w_mem[w_addr];
  end

  // Output stream transfers, seen with the same pre-edge values as the FIFO
  always @(posedge clk) begin
    if (rst_n && coef_valid && coef_ready) begin
      got_q.push_back(coef);
    end
  end

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic report_and_finish();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic check(input string msg, input logic signed [63:0] got,
                       input logic signed [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s: got %0d, expected %0d", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic set_node(input int k, input int len, input logic tgt);
    node_mem[k] = '{row_len: gat_pkg::row_len_t'(len), is_target: tgt};
  endtask

  // Fresh sparse entries and weights; positive keeps every product above zero
  task automatic randomize_data(input bit positive);
    for (int a = 0; a < 64; a++) begin
      if (positive) begin
        h_mem[a].value = gat_pkg::data_t'(xorshift32() % 50 + 1);
      end else begin
        h_mem[a].value = gat_pkg::data_t'(xorshift32());
      end
      h_mem[a].col = gat_pkg::col_idx_t'(xorshift32());
    end
    for (int a = 0; a < 16; a++) begin
      for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
        if (positive) begin
          w_mem[a].w[j] = gat_pkg::data_t'(xorshift32() % 50 + 1);
        end else begin
          w_mem[a].w[j] = gat_pkg::data_t'(xorshift32());
        end
      end
    end
  endtask

  task automatic init_memories();
    for (int k = 0; k < 16; k++) begin
      node_mem[k] = gat_pkg::node_info_t'(xorshift32());
    end
    randomize_data(1'b0);
  endtask

  // Expected coefficients straight from the layer equations
  task automatic compute_expected(input int n);
    int     p;
    longint wh [gat_pkg::NUM_FEAT_OUT];
    longint tgt_self;
    longint nbr;
    longint s;
    gat_pkg::h_entry_t e;
    p = 0;
    tgt_self = 0;
    exp_q.delete();
    for (int k = 0; k < n; k++) begin
      for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
        wh[j] = 0;
      end
      for (int i = 0; i < int'(node_mem[k].row_len); i++) begin
        e = h_mem[p];
        for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
          wh[j] += longint'($signed(e.value)) * longint'($signed(w_mem[e.col].w[j]));
        end
        p++;
      end
      if (node_mem[k].is_target) begin
        tgt_self = 0;
        for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
          tgt_self += longint'($signed(attn.self_half[j])) * wh[j];
        end
      end
      nbr = 0;
      for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
        nbr += longint'($signed(attn.nbr_half[j])) * wh[j];
      end
      s = tgt_self + nbr;
      if (s < 0) begin
        s = s >>> gat_pkg::LEAKY_SHIFT;
      end
      exp_q.push_back(gat_pkg::coef_t'(s));
    end
  endtask

  task automatic start_run(input string name, input int n);
    compute_expected(n);
    got_q.delete();
    @(negedge clk);
    start    = 1'b1;
    node_cnt = gat_pkg::node_cnt_t'(n);
    @(negedge clk);
    start = 1'b0;
    check($sformatf("%s: ready_o low after start", name), ready, 0);
  endtask

  task automatic wait_for_ready(input int limit);
    int n;
    n = 0;
    while (!ready && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!ready) begin
      $display("timeout: ready_o did not return high within %0d cycles", limit);
      timeouts++;
      report_and_finish();
    end
  endtask

  task automatic wait_for_drain(input int limit);
    int n;
    n = 0;
    while (coef_valid && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (coef_valid) begin
      $display("timeout: coefficient stream did not drain within %0d cycles", limit);
      timeouts++;
      report_and_finish();
    end
  endtask

  task automatic compare_stream(input string name);
    check($sformatf("%s: coefficient count", name), got_q.size(), exp_q.size());
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      check($sformatf("%s: coefficient %0d", name, i), got_q[i], exp_q[i]);
    end
  endtask

  task automatic collect_results(input string name);
    wait_for_ready(600);
    wait_for_drain(100);
    compare_stream(name);
  endtask

  task automatic check_reset_state();
    check("reset: ready_o", ready, 1);
    check("reset: coef_valid_o", coef_valid, 0);
  endtask

  task automatic single_target_node();
    set_node(0, 3, 1'b1);
    h_mem[0] = '{value: 8'sd5, col: 4'd2};
    h_mem[1] = '{value: -8'sd3, col: 4'd7};
    h_mem[2] = '{value: 8'sd12, col: 4'd11};
    attn = '{self_half: {8'sd3, -8'sd2, 8'sd1, 8'sd4}, nbr_half: {-8'sd1, 8'sd2, 8'sd5, -8'sd3}};
    start_run("single node", 1);
    collect_results("single node");
  endtask

  task automatic random_subgraph();
    randomize_data(1'b0);
    for (int k = 0; k < 6; k++) begin
      set_node(k, 1 + int'(xorshift32() % 8), k == 0);
    end
    for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
      attn.self_half[j] = gat_pkg::data_t'(xorshift32());
      attn.nbr_half[j]  = gat_pkg::data_t'(xorshift32());
    end
    start_run("subgraph", 6);
    collect_results("subgraph");
  endtask

  task automatic negative_sums();
    randomize_data(1'b1);
    for (int k = 0; k < 5; k++) begin
      set_node(k, 1 + int'(xorshift32() % 6), k == 0);
    end
    for (int j = 0; j < gat_pkg::NUM_FEAT_OUT; j++) begin
      attn.self_half[j] = gat_pkg::data_t'(-1 - int'(xorshift32() % 30));
      attn.nbr_half[j]  = gat_pkg::data_t'(-1 - int'(xorshift32() % 30));
    end
    start_run("negative", 5);
    collect_results("negative");
  endtask

  task automatic two_subgraphs();
    randomize_data(1'b0);
    for (int k = 0; k < 8; k++) begin
      set_node(k, (k == 2) ? 0 : 1 + int'(xorshift32() % 6), k == 0 || k == 4);
    end
    start_run("two subgraphs", 8);
    collect_results("two subgraphs");
    // Empty run comes back two cycles after the start pulse
    start_run("empty run", 0);
    @(negedge clk);
    check("empty run: ready_o two cycles after start", ready, 1);
    repeat (5) @(negedge clk);
    check("empty run: coefficient count", got_q.size(), 0);
    check("empty run: coef_valid_o", coef_valid, 0);
  endtask

  task automatic held_back_pressure();
    randomize_data(1'b0);
    for (int k = 0; k < 12; k++) begin
      set_node(k, 1 + int'(xorshift32() % 5), k == 0 || k == 7);
    end
    @(negedge clk);
    coef_ready = 1'b0;
    start_run("back-pressure", 12);
    for (int c = 0; c < 150; c++) begin
      @(negedge clk);
      check("back-pressure: ready_o held low", ready, 0);
    end
    check("back-pressure: FIFO holds data", coef_valid, 1);
    // Head of the stream stays put until it is taken
    check("back-pressure: head coefficient held", coef, exp_q[0]);
    coef_ready = 1'b1;
    collect_results("back-pressure");
  endtask

  initial begin
    errors     = 0;
    timeouts   = 0;
    rng        = 32'd5;
    rst_n      = 1'b0;
    start      = 1'b0;
    node_cnt   = '0;
    attn       = '0;
    coef_ready = 1'b1;
    init_memories();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    single_target_node();
    random_subgraph();
    negative_sums();
    two_subgraphs();
    held_back_pressure();
    report_and_finish();
  end

endmodule

// File: sim.f
src/gat_pkg.sv
src/sparse_feature_mult.sv
src/attention_coef.sv
src/coef_fifo.sv
src/gat_coef_top.sv
sim/tb_clock.sv
sim/gat_coef_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gat_coef_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
